// ==== build.f ====
+incdir+.
merge_pkg.sv
merge_stream_if.sv
grant_arbiter.sv
ingress_arbiter.sv
merge_fifo.sv
egress_port.sv
req_merge_top.sv
tb_req_merge.sv

// ==== egress_port.sv ====
// Downstream must return no more credits than it was given; overflow is not guarded
`timescale 1ns/1ps
`include "merge_cfg.svh"

module egress_port (
  input  logic                     clk,
  input  logic                     rst_n,
  merge_stream_if.receiver         in_link,
  output logic                     out_valid,
  output merge_pkg::src_id_t       out_src,
  output logic [`MERGE_DATA_W-1:0] out_data,
  input  logic                     out_credit
);

  localparam int DN_W = $clog2(`MERGE_OUT_CREDITS + 1);

  merge_pkg::merge_entry_t held;
  logic                    full;
  logic [DN_W-1:0]         dn_credits;
  logic                    send;

  assign send = full && (dn_credits != '0);

  always_ff @(posedge clk) begin
    if (in_link.valid) begin
      held <= '{src: in_link.src, data: in_link.data};
    end
  end

  // Load and send never meet, the FIFO waits for our credit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_link.valid) begin
      full <= 1'b1;
    end else if (send) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dn_credits <= DN_W'(`MERGE_OUT_CREDITS);
    end else begin
      case ({send, out_credit})
        2'b10:   dn_credits <= dn_credits - 1'b1;
        2'b01:   dn_credits <= dn_credits + 1'b1;
        default: dn_credits <= dn_credits;
      endcase
    end
  end

  assign out_valid      = send;
  assign out_src        = held.src;
  assign out_data       = held.data;
  assign in_link.credit = send;  // Register free again

endmodule

// ==== grant_arbiter.sv ====
// Grant appears one cycle after the decision edge; LFSR and RR pointer move only on real grants
`timescale 1ns/1ps

module grant_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [3:0]           req,
  input  logic                 enable,
  input  merge_pkg::arb_mode_e mode,
  output logic [3:0]           gnt
);

  logic [3:0] gnt_next;
  logic [1:0] last_ptr;  // Last granted source, kept across mode changes
  logic [2:0] lfsr;      // Bit 0 is s1, bit 2 is s3
  logic       lfsr_fb;
  logic [1:0] rand_top;

  // Source top first, the rest in ascending order
  function automatic logic [3:0] fixed_pick(input logic [3:0] r, input logic [1:0] top);
    logic [3:0] pick;
    pick = 4'b0000;
    if (r[top]) begin
      pick[top] = 1'b1;
    end else begin
      for (int i = 3; i >= 0; i--) begin
        if (r[i] && (i != top)) begin
          pick = 4'b0001 << i;  // Lowest index lands last
        end
      end
    end
    return pick;
  endfunction

  // Upward search starting one past the last grant
  function automatic logic [3:0] rr_pick(input logic [3:0] r, input logic [1:0] last);
    logic [3:0] pick;
    logic [1:0] idx;
    pick = 4'b0000;
    for (int i = 4; i >= 1; i--) begin
      idx = last + 2'(i);
      if (r[idx]) begin
        pick = 4'b0001 << idx;
      end
    end
    return pick;
  endfunction

  assign lfsr_fb  = lfsr[0] ^ lfsr[2];
  assign rand_top = lfsr[2:1];

  always_comb begin
    gnt_next = 4'b0000;
    if (enable) begin
      case (mode)
        merge_pkg::MODE_FIX0,
        merge_pkg::MODE_FIX1,
        merge_pkg::MODE_FIX2,
        merge_pkg::MODE_FIX3: gnt_next = fixed_pick(req, mode[1:0]);
        merge_pkg::MODE_RR:   gnt_next = rr_pick(req, last_ptr);
        merge_pkg::MODE_RAND: gnt_next = fixed_pick(req, rand_top);
        default:              gnt_next = 4'b0000;  // Off, codes 6 and 7
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt      <= 4'b0000;
      last_ptr <= 2'd0;    // First RR search starts at source 1
      lfsr     <= 3'b001;
    end else begin
      gnt <= gnt_next;
      if (|gnt_next) begin
        last_ptr <= merge_pkg::onehot_to_id(gnt_next);
        lfsr     <= {lfsr[1:0], lfsr_fb};
      end
    end
  end

endmodule

// ==== ingress_arbiter.sv ====
// Sources must hold req and data until accept; at most one accept per cycle
`timescale 1ns/1ps
`include "merge_cfg.svh"

module ingress_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [3:0]                    req,
  input  logic [3:0][`MERGE_DATA_W-1:0] src_data,
  input  merge_pkg::arb_mode_e          mode,
  output logic [3:0]                    accept,
  merge_stream_if.sender                fifo_link
);

  localparam int CRED_W = $clog2(`MERGE_FIFO_DEPTH + 1);

  logic [3:0]                    gnt;
  logic [3:0]                    req_m;
  logic                          enable;
  logic                          issue;
  logic [CRED_W-1:0]             credits;
  logic [3:0][`MERGE_DATA_W-1:0] words_q;
  merge_pkg::src_id_t            src_idx;

  assign req_m  = req & ~gnt;  // Source being accepted sits this one out
  assign enable = (credits != '0);

  // Mirrors when the arbiter hands out a non-zero grant
  assign issue = enable && (|req_m) && (mode <= merge_pkg::MODE_RAND);

  grant_arbiter grant_arbiter_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req_m),
    .enable (enable),
    .mode   (mode),
    .gnt    (gnt)
  );

  // Paid at the decision edge, before valid shows up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CRED_W'(`MERGE_FIFO_DEPTH);
    end else begin
      case ({issue, fifo_link.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Words as seen at the decision edge
  always_ff @(posedge clk) begin
    if (issue) begin
      words_q <= src_data;
    end
  end

  assign src_idx = merge_pkg::onehot_to_id(gnt);
  assign accept  = gnt;

  assign fifo_link.valid = |gnt;
  assign fifo_link.src   = src_idx;
  assign fifo_link.data  = words_q[src_idx];

endmodule

// ==== merge_cfg.svh ====
// Build-time sizes only; MERGE_FIFO_DEPTH must be 2 or more and credits at least 1
`ifndef MERGE_CFG_SVH
`define MERGE_CFG_SVH

// Width of one source data word
`define MERGE_DATA_W 8

// FIFO entries, also the producer credit count after reset
`define MERGE_FIFO_DEPTH 4

// Downstream credits held by the egress port after reset
`define MERGE_OUT_CREDITS 2

`endif

// ==== merge_fifo.sv ====
// Relies on the sender honoring its credits; a push into a full buffer is never checked
`timescale 1ns/1ps
`include "merge_cfg.svh"

module merge_fifo (
  input  logic             clk,
  input  logic             rst_n,
  merge_stream_if.receiver in_link,
  merge_stream_if.sender   out_link
);

  localparam int DEPTH = `MERGE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  merge_pkg::merge_entry_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             out_cred;  // Egress has a single slot
  logic             send;

  // Wraps for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign send = (count != '0) && out_cred;

  always_ff @(posedge clk) begin
    if (in_link.valid) begin
      mem[wr_ptr] <= '{src: in_link.src, data: in_link.data};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_link.valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (send) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({in_link.valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cred <= 1'b1;
    end else begin
      case ({send, out_link.credit})
        2'b10:   out_cred <= 1'b0;
        2'b01:   out_cred <= 1'b1;
        default: out_cred <= out_cred;
      endcase
    end
  end

  assign out_link.valid  = send;
  assign out_link.src    = mem[rd_ptr].src;
  assign out_link.data   = mem[rd_ptr].data;
  assign in_link.credit  = send;  // Slot freed by this pop

endmodule

// ==== merge_pkg.sv ====
// Shared merger types; the data field width follows MERGE_DATA_W from the cfg header
`include "merge_cfg.svh"

package merge_pkg;

  // Codes 0..3 put that source on top, 7 behaves like off
  typedef enum logic [2:0] {
    MODE_FIX0 = 3'd0,
    MODE_FIX1 = 3'd1,
    MODE_FIX2 = 3'd2,
    MODE_FIX3 = 3'd3,
    MODE_RR   = 3'd4,
    MODE_RAND = 3'd5,
    MODE_OFF  = 3'd6
  } arb_mode_e;

  typedef logic [1:0] src_id_t;

  typedef struct packed {
    src_id_t                  src;
    logic [`MERGE_DATA_W-1:0] data;
  } merge_entry_t;

  // Only meaningful for one-hot or zero input
  function automatic src_id_t onehot_to_id(input logic [3:0] oh);
    return {oh[3] | oh[2], oh[3] | oh[1]};
  endfunction

endpackage

// ==== merge_stream_if.sv ====
// Credit link with no ready signal; the sender must never assert valid without a credit
`timescale 1ns/1ps
`include "merge_cfg.svh"

interface merge_stream_if;

  logic                     valid;
  merge_pkg::src_id_t       src;
  logic [`MERGE_DATA_W-1:0] data;
  logic                     credit;  // One-cycle pulse per freed slot

  modport sender (
    output valid,
    output src,
    output data,
    input  credit
  );

  modport receiver (
    input  valid,
    input  src,
    input  data,
    output credit
  );

endinterface

// ==== req_merge_top.sv ====
// Four-source merger; arb_mode codes 6 and 7 stop all grants, out_credit is one pulse per word
`timescale 1ns/1ps
`include "merge_cfg.svh"

module req_merge_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [3:0]                    req,
  input  logic [3:0][`MERGE_DATA_W-1:0] src_data,
  input  logic [2:0]                    arb_mode,
  output logic [3:0]                    accept,
  output logic                          out_valid,
  output merge_pkg::src_id_t            out_src,
  output logic [`MERGE_DATA_W-1:0]      out_data,
  input  logic                          out_credit
);

  merge_pkg::arb_mode_e mode;

  merge_stream_if fifo_link ();
  merge_stream_if out_link ();

  assign mode = merge_pkg::arb_mode_e'(arb_mode);

  ingress_arbiter ingress_arbiter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .src_data  (src_data),
    .mode      (mode),
    .accept    (accept),
    .fifo_link (fifo_link.sender)
  );

  merge_fifo merge_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_link  (fifo_link.receiver),
    .out_link (out_link.sender)
  );

  egress_port egress_port_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_link    (out_link.receiver),
    .out_valid  (out_valid),
    .out_src    (out_src),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

endmodule

// ==== tb_req_merge.sv ====
// Directed tests for the merger; checks grant order and delivered content, not exact latency
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tb_req_merge;

  logic                          clk;
  logic                          rst_n;
  logic [3:0]                    req;
  logic [3:0][`MERGE_DATA_W-1:0] src_data;
  logic [2:0]                    arb_mode;
  logic [3:0]                    accept;
  logic                          out_valid;
  merge_pkg::src_id_t            out_src;
  logic [`MERGE_DATA_W-1:0]      out_data;
  logic                          out_credit;

  logic [31:0]        seed;
  logic               stall;           // Downstream holds back credits
  int                 words_left [4];
  int                 owed;
  int                 acc_count;
  int                 out_count;
  string              test_name;
  logic [3:0]         req_prev;
  logic [3:0]         acc_prev;
  logic [2:0]         mode_prev;
  merge_pkg::src_id_t model_last;      // Last granted source
  logic [2:0]         model_lfsr;

  merge_pkg::src_id_t      acc_q [$];  // Accept order of the current test
  merge_pkg::merge_entry_t exp_q [$];

  req_merge_top req_merge_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .src_data   (src_data),
    .arb_mode   (arb_mode),
    .accept     (accept),
    .out_valid  (out_valid),
    .out_src    (out_src),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [`MERGE_DATA_W-1:0] next_word();
    seed = lcg_next(seed);
    return seed[31 -: `MERGE_DATA_W];
  endfunction

  // Three-stage shift register with feedback from first and last stage
  function automatic logic [2:0] lfsr_step(input logic [2:0] l);
    return {l[1], l[0], l[2] ^ l[0]};
  endfunction

  // Winner among cand for one decision
  function automatic merge_pkg::src_id_t expected_pick(input logic [3:0] cand,
      input logic [2:0] mode, input merge_pkg::src_id_t last, input logic [2:0] lfsr);
    merge_pkg::src_id_t top;
    merge_pkg::src_id_t pick;
    int                 idx;
    logic               found;
    found = 1'b0;
    pick  = 2'd0;
    if (mode == merge_pkg::MODE_RR) begin
      for (int k = 1; k <= 4; k++) begin
        idx = (int'(last) + k) % 4;
        if (cand[idx] && !found) begin
          pick  = 2'(idx);
          found = 1'b1;
        end
      end
    end else begin
      top = (mode == merge_pkg::MODE_RAND) ? lfsr[2:1] : mode[1:0];
      if (cand[top]) begin
        pick = top;
      end else begin
        for (int i = 0; i < 4; i++) begin
          if (cand[i] && (i != int'(top)) && !found) begin
            pick  = 2'(i);
            found = 1'b1;
          end
        end
      end
    end
    return pick;
  endfunction

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_problem(input string what);
    $display("Failure in %s: %s", test_name, what);
    stop_on_failure();
  endtask

  task automatic check_src(input string name, input merge_pkg::src_id_t exp,
      input merge_pkg::src_id_t act);
    if (act !== exp) begin
      $display("ERROR: %s expected source %0d, actual source %0d", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_entry(input string name, input merge_pkg::merge_entry_t exp,
      input merge_pkg::merge_entry_t act);
    if (act !== exp) begin
      $display("ERROR: %s expected src %0d data 0x%0h, actual src %0d data 0x%0h",
               name, exp.src, exp.data, act.src, act.data);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
      input int act);
    if (act != exp) begin
      $display("ERROR: %s expected %0d %s, actual %0d %s", name, exp, what, act, what);
      stop_on_failure();
    end
  endtask

  // Sources, scoreboard and downstream model in one place
  always @(posedge clk) begin : monitor
    merge_pkg::src_id_t      got_src;
    merge_pkg::src_id_t      exp_src;
    merge_pkg::merge_entry_t got_ent;
    logic [3:0]              cand;
    int                      owed_next;
    if (!rst_n) begin
      model_last = 2'd0;
      model_lfsr = 3'b001;
      acc_prev   = 4'b0000;
      owed       = 0;
      out_credit <= 1'b0;
    end else begin
      if (accept != 4'b0000) begin
        if (!$onehot(accept)) begin
          report_problem("more than one accept bit high in the same cycle");
        end
        got_src = 2'd0;
        for (int i = 0; i < 4; i++) begin
          if (accept[i]) begin
            got_src = 2'(i);
          end
        end
        cand = req_prev & ~acc_prev;  // Source in its accept cycle sits out
        if (cand == 4'b0000) begin
          report_problem("accept given to a source that was not requesting");
        end
        if (mode_prev > 3'd5) begin
          report_problem("accept given while arbitration is off");
        end
        exp_src = expected_pick(cand, mode_prev, model_last, model_lfsr);
        check_src(test_name, exp_src, got_src);
        model_last = got_src;
        model_lfsr = lfsr_step(model_lfsr);
        acc_q.push_back(got_src);
        acc_count++;
        exp_q.push_back('{src: got_src, data: src_data[got_src]});
        words_left[got_src]--;
        if (words_left[got_src] > 0) begin
          src_data[got_src] <= next_word();
        end else begin
          req[got_src] <= 1'b0;
        end
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          report_problem("output word appeared with nothing expected");
        end
        got_ent = '{src: out_src, data: out_data};
        check_entry(test_name, exp_q.pop_front(), got_ent);
        out_count++;
      end
      owed_next = owed + (out_valid ? 1 : 0);
      if (!stall && (owed_next > 0)) begin
        out_credit <= 1'b1;
        owed_next--;
      end else begin
        out_credit <= 1'b0;
      end
      owed = owed_next;
      acc_prev = accept;
    end
    req_prev  = req;
    mode_prev = arb_mode;
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic set_mode(input logic [2:0] m);
    @(posedge clk);
    arb_mode <= m;
  endtask

  // New words for idle sources only
  task automatic offer(input int n0, input int n1, input int n2, input int n3);
    int n [4];
    n = '{n0, n1, n2, n3};
    @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      if (n[i] > 0) begin
        words_left[i] = n[i];
        req[i]      <= 1'b1;
        src_data[i] <= next_word();
      end
    end
  endtask

  task automatic wait_idle(input int limit);
    int cyc;
    cyc = 0;
    while ((words_left.sum() != 0) || (exp_q.size() != 0)) begin
      @(negedge clk);
      cyc++;
      if (cyc > limit) begin
        report_problem("timed out waiting for words to be accepted and delivered");
      end
    end
  endtask

  task automatic check_order(input int first, input int step);
    check_count(test_name, "accepts", 4, acc_q.size());
    for (int j = 0; j < 4; j++) begin
      check_src(test_name, 2'((first + j * step) % 4), acc_q[j]);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    for (int cyc = 0; cyc < 20; cyc++) begin
      @(negedge clk);
      if ((accept !== 4'b0000) || (out_valid !== 1'b0)) begin
        report_problem("accept or out_valid not low after reset");
      end
    end
  endtask

  task automatic test_fixed();
    int j;
    for (int k = 0; k < 4; k++) begin
      test_name = $sformatf("fixed_priority_%0d", k);
      set_mode(3'(k));
      acc_q.delete();
      offer(1, 1, 1, 1);
      wait_idle(200);
      check_count(test_name, "accepts", 4, acc_q.size());
      check_src(test_name, 2'(k), acc_q[0]);
      j = 1;
      for (int i = 0; i < 4; i++) begin
        if (i != k) begin
          check_src(test_name, 2'(i), acc_q[j]);  // Rest ascending
          j++;
        end
      end
    end
  endtask

  task automatic test_round_robin();
    test_name = "round_robin";
    apply_reset();
    set_mode(merge_pkg::MODE_RR);
    acc_q.delete();
    offer(1, 1, 1, 1);
    wait_idle(200);
    check_order(1, 1);  // Search starts at source 1
    acc_q.delete();
    offer(3, 1, 2, 4);
    wait_idle(400);
    check_count(test_name, "accepts", 10, acc_q.size());
  endtask

  task automatic test_random();
    test_name = "random";
    set_mode(merge_pkg::MODE_RAND);
    acc_q.delete();
    offer(2, 3, 1, 2);
    wait_idle(400);
    offer(0, 4, 4, 1);
    wait_idle(400);
    check_count(test_name, "accepts", 17, acc_q.size());
  endtask

  task automatic test_backpressure();
    int base_acc;
    int base_out;
    test_name = "backpressure";
    base_acc  = acc_count;
    base_out  = out_count;
    @(posedge clk);
    stall <= 1'b1;
    set_mode(merge_pkg::MODE_RR);
    offer(3, 3, 3, 3);
    for (int cyc = 0; cyc < 60; cyc++) begin
      @(negedge clk);
      if (acc_count - base_acc > `MERGE_FIFO_DEPTH + 1 + `MERGE_OUT_CREDITS) begin
        report_problem("more words accepted than the buffers can hold while stalled");
      end
    end
    if (acc_count == base_acc) begin
      report_problem("no word accepted while downstream stalled");
    end
    @(posedge clk);
    stall <= 1'b0;
    wait_idle(600);
    check_count(test_name, "accepts", 12, acc_count - base_acc);
    check_count(test_name, "output words", 12, out_count - base_out);
  endtask

  task automatic test_off();
    test_name = "off_mode";
    set_mode(merge_pkg::MODE_OFF);
    acc_q.delete();
    offer(1, 1, 1, 1);
    for (int cyc = 0; cyc < 30; cyc++) begin
      @(negedge clk);
      if (accept !== 4'b0000) begin
        report_problem("accept seen in off mode");
      end
    end
    set_mode(merge_pkg::MODE_FIX0);
    wait_idle(200);
    check_order(0, 1);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = 4'b0000;
    src_data   = '0;
    arb_mode   = 3'd0;
    out_credit = 1'b0;
    stall      = 1'b0;
    seed       = 32'h0577_462d;
    words_left = '{0, 0, 0, 0};
    owed       = 0;
    acc_count  = 0;
    out_count  = 0;
    req_prev   = 4'b0000;
    acc_prev   = 4'b0000;
    mode_prev  = 3'd0;
    model_last = 2'd0;
    model_lfsr = 3'b001;
    test_name  = "reset";
    apply_reset();
    test_reset();
    test_fixed();
    test_round_robin();
    test_random();
    test_backpressure();
    test_off();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
